/* project.f */
+incdir+design
design/ifu_pkg.sv
design/ifu_l1i.sv
design/ifu_fetch_ctrl.sv
design/ifu_top.sv
test/ifu_checker.sv
test/ifu_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module ifu_tb \
  -f project.f \
  -o ifu_sim

./obj_dir/ifu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
echo "simulation finished cleanly"

/* test/ifu_tb.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_tb;

  logic           clock;
  logic           reset;
  ifu_pkg::addr_t npc;
  logic           pc_change;
  logic           pc_retire;
  logic           load_retire;
  logic           prev_valid;
  logic           next_ready;
  ifu_pkg::inst_t rdata;
  logic           rvalid;
  ifu_pkg::inst_t out_inst;
  ifu_pkg::addr_t out_pc;
  logic           out_valid;
  logic           out_ready;
  logic           flush;
  ifu_pkg::addr_t araddr;
  logic           arvalid;
  logic           required;

  ifu_pkg::inst_t program_mem [0:63];
  logic [7:0]     pattern [ifu_pkg::addr_t];  // Branch outcome per visit.
  ifu_pkg::addr_t jump_tab [ifu_pkg::addr_t];
  int             visits [ifu_pkg::addr_t];
  bit             fetched [ifu_pkg::addr_t];

  int             due_q[$];
  int             kind_q[$];
  ifu_pkg::addr_t npc_q[$];
  bit             stall_q[$];

  int             seed = 53616;
  int             cycle = 0;
  int             idle_cycles = 0;
  int             req_count = 0;
  int             req_mark = 0;
  ifu_pkg::addr_t arch_pc;
  ifu_pkg::addr_t watch_pc;
  bit             watch = 0;
  bit             trained = 0;
  bit             stall_wait = 0;
  bit             flush_due = 0;
  bit             flush_seen = 0;
  bit             fence_seen = 0;
  bit             done = 0;

  ifu_top u_dut (
    .clock       (clock),
    .reset       (reset),
    .npc         (npc),
    .pc_change   (pc_change),
    .pc_retire   (pc_retire),
    .load_retire (load_retire),
    .prev_valid  (prev_valid),
    .next_ready  (next_ready),
    .rdata       (rdata),
    .rvalid      (rvalid),
    .out_inst    (out_inst),
    .out_pc      (out_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .flush       (flush),
    .araddr      (araddr),
    .arvalid     (arvalid),
    .required    (required)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic ifu_pkg::addr_t at(logic [7:0] off);
    return `IFU_PC_INIT + {24'd0, off};
  endfunction

  // Harmless addi with fields hashed from the address.
  function automatic ifu_pkg::inst_t fill_word(ifu_pkg::addr_t addr);
    logic [31:0] h;
    h = addr * 32'h9e37_79b9;
    return {h[31:15], 3'b000, h[11:7], 7'h13};
  endfunction

  function automatic ifu_pkg::inst_t mem_word(ifu_pkg::addr_t addr);
    return program_mem[addr[7:2]];
  endfunction

  function automatic ifu_pkg::inst_t enc_branch(logic [12:0] off);
    return {off[12], off[10:5], 13'd0, off[4:1], off[11], `IFU_OP_BRANCH};
  endfunction

  function automatic ifu_pkg::inst_t enc_jal(logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd0, `IFU_OP_JAL};
  endfunction

  function automatic ifu_pkg::addr_t next_arch_pc(ifu_pkg::addr_t pc, ifu_pkg::inst_t inst);
    ifu_pkg::addr_t imm_j;
    ifu_pkg::addr_t imm_b;
    int n;
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    n = visits.exists(pc) ? visits[pc] : 0;
    case (inst[6:0])
      `IFU_OP_JAL: return pc + imm_j;
      `IFU_OP_JALR, `IFU_OP_SYSTEM: return jump_tab[pc];
      `IFU_OP_BRANCH: return pattern[pc][n[2:0]] ? pc + imm_b : pc + 32'd4;
      default: return pc + 32'd4;
    endcase
  endfunction

  task automatic stop_with_error(input string msg);
    $display("Error: %s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pc(input string name, input ifu_pkg::addr_t exp,
                          input ifu_pkg::addr_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "pc mismatch");
    end
  endtask

  task automatic check_inst(input string name, input ifu_pkg::inst_t exp,
                            input ifu_pkg::inst_t act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "instruction mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  // Backend strobes come out in transfer order.
  task automatic drive_backend();
    prev_valid  = 1'b0;
    pc_change   = 1'b0;
    pc_retire   = 1'b0;
    load_retire = 1'b0;
    if (due_q.size() > 0 && due_q[0] <= cycle) begin
      prev_valid = 1'b1;
      npc        = npc_q[0];
      case (kind_q[0])
        0: pc_change = 1'b1;
        1: pc_retire = 1'b1;
        default: load_retire = 1'b1;
      endcase
      if (stall_q[0]) stall_wait = 1'b0;
      void'(due_q.pop_front());
      void'(kind_q.pop_front());
      void'(npc_q.pop_front());
      void'(stall_q.pop_front());
    end
  endtask

  task automatic take_transfer(input ifu_pkg::addr_t pc, input ifu_pkg::inst_t inst);
    ifu_pkg::addr_t tgt;
    logic [6:0]     opc;
    int             n;
    bit             stalls;
    check_inst("fetched word", mem_word(pc), inst);
    if (stall_wait) stop_with_error("instruction transferred during a stall");
    if (watch) begin
      watch = 1'b0;
      check_pc("trained target", watch_pc, pc);
    end
    if (pc != arch_pc) begin
      if (due_q.size() == 0) check_pc("architectural pc", arch_pc, pc);
      return;  // Wrong path.
    end
    if (flush_due) begin
      flush_due = 1'b0;
      if (!flush_seen) stop_with_error("no flush after a mispredicted branch");
    end
    n = visits.exists(pc) ? visits[pc] : 0;
    tgt = next_arch_pc(pc, inst);
    visits[pc] = n + 1;
    opc = inst[6:0];
    stalls = (opc == `IFU_OP_JALR) || (opc == `IFU_OP_SYSTEM) || (opc == `IFU_OP_LOAD);
    if (stalls || opc == `IFU_OP_JAL || opc == `IFU_OP_BRANCH) begin
      due_q.push_back(cycle + 2);
      kind_q.push_back(opc == `IFU_OP_LOAD ? 2 : (tgt != pc + 32'd4 ? 0 : 1));
      npc_q.push_back(opc == `IFU_OP_LOAD ? '0 : tgt);
      stall_q.push_back(stalls);
      if (stalls) stall_wait = 1'b1;
    end
    if ((pc == at(8'h50) || pc == at(8'h68)) && n == 1) begin
      watch    = 1'b1;
      watch_pc = tgt;
      trained  = 1'b1;  // Held until its resolve strobe.
    end
    if (pc == at(8'h50) && n == 2) begin
      flush_due  = 1'b1;
      flush_seen = 1'b0;
    end
    if (pc == at(8'h40) && n == 1) req_mark = req_count;  // Second loop pass.
    if (pc == at(8'h54) && req_count != req_mark) begin
      stop_with_error("bus reads while the loop should hit in the cache");
    end
    if (inst == `IFU_INST_FENCE_I) begin
      fetched.delete();
      fence_seen = 1'b1;
    end
    if (pc == at(8'h78) && fence_seen && !fetched.exists(at(8'h70))) begin
      stop_with_error("cached line not fetched again after fence.i");
    end
    arch_pc = tgt;
    if (arch_pc == at(8'hc0)) done = 1'b1;
  endtask

  initial begin : memory_model
    int             delay;
    ifu_pkg::addr_t addr;
    rvalid = 1'b0;
    rdata  = '0;
    forever begin
      @(negedge clock);
      rvalid = 1'b0;
      if (arvalid) begin
        if (araddr[3:2] != req_count[1:0]) stop_with_error("bus read out of line order");
        addr = araddr;
        fetched[araddr & 32'hffff_fff0] = 1'b1;
        req_count++;
        delay = 1 + ($random(seed) & 3);
        repeat (delay) @(negedge clock);
        check_flag("required while a word is outstanding", 1'b1, required);
        rdata  = mem_word(addr);
        rvalid = 1'b1;
      end
    end
  end

  initial begin
    reset       = 1'b1;
    npc         = '0;
    pc_change   = 1'b0;
    pc_retire   = 1'b0;
    load_retire = 1'b0;
    prev_valid  = 1'b0;
    next_ready  = 1'b0;
    arch_pc     = `IFU_PC_INIT;
    for (int i = 0; i < 64; i++) begin
      program_mem[i] = fill_word(`IFU_PC_INIT + {i[29:0], 2'b00});
    end
    program_mem[8'h50 >> 2] = enc_branch(13'h1ff0);  // Loop back to 0x40.
    program_mem[8'h64 >> 2] = enc_branch(13'd12);
    program_mem[8'h68 >> 2] = enc_jal(21'h1ffff8);
    program_mem[8'h70 >> 2] = 32'h0000_2003;         // lw.
    program_mem[8'h74 >> 2] = 32'h0000_8067;         // jalr.
    program_mem[8'h7c >> 2] = enc_jal(21'd36);
    program_mem[8'h80 >> 2] = 32'h0000_0073;         // ecall.
    program_mem[8'h90 >> 2] = `IFU_INST_FENCE_I;
    program_mem[8'h94 >> 2] = 32'h0000_8067;
    pattern[at(8'h50)]  = 8'b0000_0011;
    pattern[at(8'h64)]  = 8'b0000_0100;
    jump_tab[at(8'h74)] = at(8'h80);
    jump_tab[at(8'h80)] = at(8'h90);
    jump_tab[at(8'h94)] = at(8'h78);

    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    while (!done) begin
      @(negedge clock);
      cycle++;
      idle_cycles++;
      if (idle_cycles > 2000) stop_with_error("no instruction transferred for 2000 cycles");
      drive_backend();
      next_ready = ($random(seed) & 3) != 0;
      #1;
      check_flag("out_ready", !out_valid, out_ready);
      if (flush) flush_seen = 1'b1;
      if (flush && trained) stop_with_error("flush rose after a trained prediction");
      if (due_q.size() == 0) trained = 1'b0;
      if (out_valid && next_ready) begin
        idle_cycles = 0;
        take_transfer(out_pc, out_inst);
      end
    end

    if (u_dut.u_checker.fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "protocol assertions failed");
    end
  end

endmodule

/* test/ifu_checker.sv */
`timescale 1ns/1ps

module ifu_checker (
  input logic           clock,
  input logic           reset,
  input logic           arvalid,
  input logic           required,
  input logic           flush,
  input logic           out_valid,
  input logic           next_ready,
  input ifu_pkg::addr_t out_pc,
  input ifu_pkg::inst_t out_inst
);

  int fail_count = 0;

  a_req_level: assert property (@(posedge clock) disable iff (reset)
    arvalid |-> required)
    else begin
      $error("arvalid outside a held request");
      fail_count++;
    end

  a_flush_excl: assert property (@(posedge clock) disable iff (reset)
    !(flush && out_valid))
    else begin
      $error("flush and out_valid high together");
      fail_count++;
    end

  // Decode side stalled.
  a_hold: assert property (@(posedge clock) disable iff (reset)
    (out_valid && !next_ready) |=> ($stable(out_pc) && $stable(out_inst)))
    else begin
      $error("output changed while stalled");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clock)
    $fell(reset) |-> !(out_valid || flush || arvalid || required))
    else begin
      $error("outputs not quiet after reset");
      fail_count++;
    end

endmodule

bind ifu_top ifu_checker u_checker (
  .clock      (clock),
  .reset      (reset),
  .arvalid    (arvalid),
  .required   (required),
  .flush      (flush),
  .out_valid  (out_valid),
  .next_ready (next_ready),
  .out_pc     (out_pc),
  .out_inst   (out_inst)
);

/* design/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
  input  logic           clock,
  input  logic           reset,
  input  ifu_pkg::addr_t npc,
  input  logic           pc_change,
  input  logic           pc_retire,
  input  logic           load_retire,
  input  logic           prev_valid,
  input  logic           next_ready,
  input  ifu_pkg::inst_t rdata,
  input  logic           rvalid,
  output ifu_pkg::inst_t out_inst,
  output ifu_pkg::addr_t out_pc,
  output logic           out_valid,
  output logic           out_ready,
  output logic           flush,
  output ifu_pkg::addr_t araddr,
  output logic           arvalid,
  output logic           required
);

  logic hit;
  logic idle;
  logic invalidate;

  // The PC and the fetched word go to decode as they are.
  ifu_fetch_ctrl u_ctrl (
    .clock       (clock),
    .reset       (reset),
    .npc         (npc),
    .pc_change   (pc_change),
    .pc_retire   (pc_retire),
    .load_retire (load_retire),
    .prev_valid  (prev_valid),
    .next_ready  (next_ready),
    .inst        (out_inst),
    .hit         (hit),
    .idle        (idle),
    .pc          (out_pc),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .flush       (flush),
    .invalidate  (invalidate)
  );

  ifu_l1i u_l1i (
    .clock      (clock),
    .reset      (reset),
    .pc         (out_pc),
    .invalidate (invalidate),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .inst       (out_inst),
    .hit        (hit),
    .idle       (idle),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .required   (required)
  );

endmodule

/* design/ifu_fetch_ctrl.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_fetch_ctrl (
  input  logic           clock,
  input  logic           reset,
  input  ifu_pkg::addr_t npc,
  input  logic           pc_change,
  input  logic           pc_retire,
  input  logic           load_retire,
  input  logic           prev_valid,
  input  logic           next_ready,
  input  ifu_pkg::inst_t inst,
  input  logic           hit,
  input  logic           idle,
  output ifu_pkg::addr_t pc,
  output logic           out_valid,
  output logic           out_ready,
  output logic           flush,
  output logic           invalidate
);

  ifu_pkg::addr_t pc_q;
  ifu_pkg::addr_t btb;
  ifu_pkg::addr_t btb_jal;
  ifu_pkg::addr_t spec_target;
  ifu_pkg::addr_t redirect_q;

  logic       lsu_hazard;
  logic       branch_hazard;
  logic       hazard_jal;
  logic       spec;
  logic       spec_is_b;
  logic       bad_spec;

  logic [6:0] opcode;
  logic       is_jal;
  logic       is_jalr;
  logic       is_branch;
  logic       is_load;
  logic       is_store;
  logic       is_sys;
  logic       is_fence_i;

  logic       change_s;
  logic       retire_s;
  logic       load_s;
  logic       resolve;
  logic       resolved_jal;
  logic       good_now;
  logic       bad_now;
  logic       redirect;
  logic       valid;
  logic       fire;

  // Predecode.
  assign opcode     = inst[6:0];
  assign is_jal     = (opcode == `IFU_OP_JAL);
  assign is_jalr    = (opcode == `IFU_OP_JALR);
  assign is_branch  = (opcode == `IFU_OP_BRANCH);
  assign is_load    = (opcode == `IFU_OP_LOAD);
  assign is_store   = (opcode == `IFU_OP_STORE);
  assign is_sys     = (opcode == `IFU_OP_SYSTEM);
  assign is_fence_i = (inst == `IFU_INST_FENCE_I);

  assign change_s = prev_valid & pc_change;
  assign retire_s = prev_valid & pc_retire;
  assign load_s   = prev_valid & load_retire;
  assign resolve  = change_s | retire_s;

  // The oldest unresolved control transfer is the speculation if one exists.
  assign resolved_jal = spec ? !spec_is_b : hazard_jal;
  assign good_now     = spec & resolve & (npc == spec_target);
  assign bad_now      = spec & resolve & (npc != spec_target);
  assign flush        = bad_spec | bad_now;
  assign redirect     = flush & next_ready & idle;

  // No memory access leaves while a guess is open.
  assign valid = hit & !lsu_hazard & !branch_hazard & !flush &
                 !(spec & (is_load | is_store));
  assign fire  = valid & next_ready;

  assign out_valid  = valid;
  assign out_ready  = !valid;
  assign invalidate = fire & is_fence_i;
  assign pc         = pc_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q          <= `IFU_PC_INIT;
      btb           <= `IFU_PC_INIT;
      btb_jal       <= `IFU_PC_INIT;
      lsu_hazard    <= 1'b0;
      branch_hazard <= 1'b0;
      spec          <= 1'b0;
      bad_spec      <= 1'b0;
    end else begin
      if (resolve) begin
        btb <= npc;
        if (resolved_jal) begin
          btb_jal <= npc;
        end
      end

      if (redirect) begin
        pc_q          <= bad_now ? npc : redirect_q;
        bad_spec      <= 1'b0;
        spec          <= 1'b0;
        branch_hazard <= 1'b0;
        lsu_hazard    <= 1'b0;
      end else begin
        if (bad_now) begin
          bad_spec <= 1'b1;
          spec     <= 1'b0;
        end
        if (good_now) begin
          spec <= 1'b0;
        end
        if (!spec && branch_hazard && resolve) begin
          branch_hazard <= 1'b0;
          pc_q          <= npc;
        end
        if (!spec && lsu_hazard && load_s) begin
          lsu_hazard <= 1'b0;
          pc_q       <= pc_q + 32'd4;
        end
        if (fire) begin
          if (is_branch || is_jal) begin
            // Backward taken, forward not taken.
            if (!spec && is_branch && (btb < pc_q)) begin
              spec      <= 1'b1;
              spec_is_b <= 1'b1;
              pc_q      <= btb;
            end else if (!spec && is_jal && (btb_jal < pc_q)) begin
              spec      <= 1'b1;
              spec_is_b <= 1'b0;
              pc_q      <= btb_jal;
            end else begin
              branch_hazard <= 1'b1;
              hazard_jal    <= is_jal;
            end
          end else if (is_jalr || is_sys) begin
            branch_hazard <= 1'b1;
            hazard_jal    <= 1'b0;
          end else if (is_load) begin
            lsu_hazard <= 1'b1;
          end else begin
            pc_q <= pc_q + 32'd4;
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fire && !spec) begin
      spec_target <= (is_branch) ? btb : btb_jal;  // Only kept if a guess is made.
    end
    if (bad_now) begin
      redirect_q <= npc;
    end
  end

endmodule

/* design/ifu_l1i.sv */
`timescale 1ns/1ps
`include "ifu_consts.svh"

module ifu_l1i (
  input  logic                   clock,
  input  logic                   reset,
  input  ifu_pkg::addr_t         pc,
  input  logic                   invalidate,
  input  ifu_pkg::inst_t         rdata,
  input  logic                   rvalid,
  output ifu_pkg::inst_t         inst,
  output logic                   hit,
  output logic                   idle,
  output ifu_pkg::addr_t         araddr,
  output logic                   arvalid,
  output logic                   required
);

  ifu_pkg::refill_state_t state;

  ifu_pkg::tag_t          tag_mem [`IFU_SETS];
  ifu_pkg::inst_t         data_mem [`IFU_SETS][`IFU_LINE_WORDS];
  logic [`IFU_SETS-1:0]   line_valid;

  ifu_pkg::tag_t          pc_tag;
  ifu_pkg::set_t          pc_set;
  ifu_pkg::word_sel_t     pc_word;

  ifu_pkg::tag_t          fill_tag;
  ifu_pkg::set_t          fill_set;
  ifu_pkg::word_sel_t     fill_word;
  logic                   fill_abort;
  logic                   fill_last;
  logic                   fill_start;
  logic                   fill_write;

  assign pc_tag  = pc[31:2+`IFU_LINE_BITS+`IFU_SET_BITS];
  assign pc_set  = pc[2+`IFU_LINE_BITS +: `IFU_SET_BITS];
  assign pc_word = pc[2 +: `IFU_LINE_BITS];

  // Combinational lookup.
  assign hit  = line_valid[pc_set] && (tag_mem[pc_set] == pc_tag);
  assign inst = data_mem[pc_set][pc_word];

  assign fill_start = (state == ifu_pkg::REFILL_IDLE) && !hit;
  assign fill_write = (state == ifu_pkg::REFILL_DATA) && rvalid;
  assign fill_last  = (fill_word == ifu_pkg::word_sel_t'(`IFU_LINE_WORDS - 1));

  assign idle     = (state == ifu_pkg::REFILL_IDLE);
  assign required = (state != ifu_pkg::REFILL_IDLE);  // Held for the whole line.
  assign arvalid  = (state == ifu_pkg::REFILL_REQ);
  assign araddr   = {fill_tag, fill_set, fill_word, 2'b00};

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= ifu_pkg::REFILL_IDLE;
      line_valid <= '0;
      fill_abort <= 1'b0;
    end else begin
      case (state)
        ifu_pkg::REFILL_IDLE: begin
          if (!hit) begin
            state              <= ifu_pkg::REFILL_REQ;
            line_valid[pc_set] <= 1'b0;  // Line is overwritten from here on.
            fill_abort         <= 1'b0;
          end
        end
        ifu_pkg::REFILL_REQ: begin
          state <= ifu_pkg::REFILL_DATA;
        end
        ifu_pkg::REFILL_DATA: begin
          if (rvalid) begin
            if (fill_last) begin
              state                <= ifu_pkg::REFILL_IDLE;
              line_valid[fill_set] <= !fill_abort;
            end else begin
              state <= ifu_pkg::REFILL_REQ;  // One word in flight at a time.
            end
          end
        end
        default: begin
          state <= ifu_pkg::REFILL_IDLE;
        end
      endcase

      // fence.i wins over a line completing in the same cycle.
      if (invalidate) begin
        line_valid <= '0;
        if (state != ifu_pkg::REFILL_IDLE) begin
          fill_abort <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_start) begin
      fill_tag        <= pc_tag;
      fill_set        <= pc_set;
      fill_word       <= '0;
      tag_mem[pc_set] <= pc_tag;
    end
    if (fill_write) begin
      data_mem[fill_set][fill_word] <= rdata;
      fill_word                     <= fill_word + 1'b1;
    end
  end

endmodule

/* design/ifu_pkg.sv */
`include "ifu_consts.svh"

package ifu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] inst_t;

  // Address split: tag | set | word | byte.
  typedef logic [`IFU_SET_BITS-1:0] set_t;
  typedef logic [`IFU_LINE_BITS-1:0] word_sel_t;
  typedef logic [31-2-`IFU_LINE_BITS-`IFU_SET_BITS:0] tag_t;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_REQ,
    REFILL_DATA
  } refill_state_t;

endpackage

/* design/ifu_consts.svh */
`ifndef IFU_CONSTS_SVH
`define IFU_CONSTS_SVH

// Fetch starts here after reset.
`define IFU_PC_INIT 32'h8000_0000

// RV32I major opcodes seen by the predecoder.
`define IFU_OP_JAL    7'b1101111
`define IFU_OP_JALR   7'b1100111
`define IFU_OP_BRANCH 7'b1100011
`define IFU_OP_LOAD   7'b0000011
`define IFU_OP_STORE  7'b0100011
`define IFU_OP_SYSTEM 7'b1110011

`define IFU_INST_FENCE_I 32'h0000_100f  // Plain fence.i, no operands.

// Cache geometry.
`define IFU_LINE_WORDS 4
`define IFU_LINE_BITS  2
`define IFU_SETS       16
`define IFU_SET_BITS   4

`endif
